// File: rtl/rv_exec_pkg.sv
// Shared types for the RV32I execute pipeline.
// Widths, class and operation encodings, and the records passed between stages.
package rv_exec_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;
    typedef logic [4:0]  opcode_t;
    typedef logic [4:0]  shamt_t;

    // Input to output, in clock cycles
    localparam int EXEC_LATENCY = 3;

    // Opcode bits 6:2
    localparam opcode_t OPC_LOAD   = 5'b00000;
    localparam opcode_t OPC_OP_IMM = 5'b00100;
    localparam opcode_t OPC_AUIPC  = 5'b00101;
    localparam opcode_t OPC_STORE  = 5'b01000;
    localparam opcode_t OPC_OP     = 5'b01100;
    localparam opcode_t OPC_LUI    = 5'b01101;
    localparam opcode_t OPC_BRANCH = 5'b11000;
    localparam opcode_t OPC_JALR   = 5'b11001;
    localparam opcode_t OPC_JAL    = 5'b11011;

    // Main-control class code
    typedef enum logic [3:0] {
        LOAD   = 4'b0000,
        OP_IMM = 4'b0010,
        AUIPC  = 4'b0011,
        STORE  = 4'b0100,
        OP     = 4'b0110,
        LUI    = 4'b0111,
        BRANCH = 4'b1100,
        JUMP   = 4'b1101
    } alu_option_e;

    typedef enum logic [3:0] {
        ADD               = 4'b0000,
        SUB               = 4'b0001,
        AND               = 4'b0010,
        OR                = 4'b0011,
        XOR               = 4'b0100,
        U_LOW_EQ          = 4'b0101,
        S_LOW_EQ          = 4'b0110,
        U_HIGH_EQ         = 4'b0111,
        S_HIGH_EQ         = 4'b1000,
        U_LOWER           = 4'b1001,
        S_LOWER           = 4'b1010,
        U_HIGHER          = 4'b1011,
        S_HIGHER          = 4'b1100,
        SHIFT_LEFT        = 4'b1101,
        SHIFT_RIGHT_LOGIC = 4'b1110,
        SHIFT_RIGHT_ARIT  = 4'b1111
    } alu_op_e;

    typedef struct packed {
        logic        valid;
        alu_option_e option;
        funct3_t     funct3;
        funct7_t     funct7;
        xlen_t       operand_a;
        xlen_t       operand_b;
        xlen_t       target;
        reg_idx_t    rd;
        logic        is_jump;
        logic        illegal;
    } dec_stage_t;

    typedef struct packed {
        logic     valid;
        alu_op_e  op;
        xlen_t    operand_a;
        xlen_t    operand_b;
        xlen_t    target;
        reg_idx_t rd;
        funct3_t  funct3;
        logic     is_branch;
        logic     is_jump;
        logic     writes_rd;
        // Loads only produce an address here
        logic     is_load;
        logic     illegal;
    } ctl_stage_t;

    typedef struct packed {
        logic     valid;
        xlen_t    result;
        reg_idx_t rd;
        logic     wb_en;
        logic     branch_taken;
        xlen_t    target;
        logic     illegal;
    } exec_result_t;

endpackage

// File: rtl/instr_decoder.sv
// Stage 1 of the execute pipeline.
// Classifies the instruction, builds its immediate, picks both ALU operands
// and computes the branch or jump target. Result is registered.
`timescale 1ns/1ns

module instr_decoder (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    in_valid,
    input  rv_exec_pkg::instr_t     instr,
    input  rv_exec_pkg::xlen_t      pc,
    input  rv_exec_pkg::xlen_t      rs1_value,
    input  rv_exec_pkg::xlen_t      rs2_value,
    output rv_exec_pkg::dec_stage_t dec
);

    rv_exec_pkg::opcode_t    opcode;
    rv_exec_pkg::xlen_t      imm_i;
    rv_exec_pkg::xlen_t      imm_s;
    rv_exec_pkg::xlen_t      imm_b;
    rv_exec_pkg::xlen_t      imm_u;
    rv_exec_pkg::xlen_t      imm_j;
    rv_exec_pkg::xlen_t      jalr_sum;
    rv_exec_pkg::dec_stage_t dec_next;

    assign opcode = instr[6:2];

    // Sign-extended immediates of every format
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    assign jalr_sum = rs1_value + imm_i;

    always_comb begin
        dec_next           = '0;
        dec_next.valid     = in_valid;
        dec_next.option    = rv_exec_pkg::LOAD;
        dec_next.funct3    = instr[14:12];
        dec_next.funct7    = instr[31:25];
        dec_next.rd        = instr[11:7];
        dec_next.operand_a = rs1_value;
        dec_next.operand_b = imm_i;
        dec_next.target    = pc + imm_b;

        case (opcode)
            rv_exec_pkg::OPC_LOAD: begin
                dec_next.option = rv_exec_pkg::LOAD;
            end
            rv_exec_pkg::OPC_OP_IMM: begin
                dec_next.option = rv_exec_pkg::OP_IMM;
            end
            rv_exec_pkg::OPC_AUIPC: begin
                dec_next.option    = rv_exec_pkg::AUIPC;
                dec_next.operand_a = pc;
                dec_next.operand_b = imm_u;
            end
            rv_exec_pkg::OPC_STORE: begin
                dec_next.option    = rv_exec_pkg::STORE;
                dec_next.operand_b = imm_s;
            end
            rv_exec_pkg::OPC_OP: begin
                dec_next.option    = rv_exec_pkg::OP;
                dec_next.operand_b = rs2_value;
            end
            rv_exec_pkg::OPC_LUI: begin
                dec_next.option    = rv_exec_pkg::LUI;
                dec_next.operand_a = '0;
                dec_next.operand_b = imm_u;
            end
            rv_exec_pkg::OPC_BRANCH: begin
                dec_next.option    = rv_exec_pkg::BRANCH;
                dec_next.operand_b = rs2_value;
            end
            rv_exec_pkg::OPC_JAL: begin
                dec_next.option    = rv_exec_pkg::JUMP;
                dec_next.operand_a = pc;
                dec_next.operand_b = 32'd4;
                dec_next.target    = pc + imm_j;
                dec_next.is_jump   = 1'b1;
            end
            rv_exec_pkg::OPC_JALR: begin
                dec_next.option    = rv_exec_pkg::JUMP;
                dec_next.operand_a = pc;
                dec_next.operand_b = 32'd4;
                // Low bit of the jump address is dropped
                dec_next.target    = {jalr_sum[31:1], 1'b0};
                dec_next.is_jump   = 1'b1;
            end
            default: begin
                // FENCE, SYSTEM and unknown opcodes
                dec_next.illegal = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        dec <= dec_next;
        if (rst) begin
            dec.valid <= 1'b0;
        end
    end

endmodule

// File: rtl/alu_controller.sv
// Stage 2 of the execute pipeline.
// Maps the main-control class and function fields to one of sixteen ALU
// operations and registers it with the operands and control bits.
`timescale 1ns/1ns

module alu_controller (
    input  logic                    clk,
    input  logic                    rst,
    input  rv_exec_pkg::dec_stage_t dec,
    output rv_exec_pkg::ctl_stage_t ctl
);

    rv_exec_pkg::alu_op_e    op_next;
    rv_exec_pkg::ctl_stage_t ctl_next;

    always_comb begin
        op_next = rv_exec_pkg::ADD;
        case (dec.option)
            rv_exec_pkg::OP_IMM: begin
                case (dec.funct3)
                    3'b010: op_next = rv_exec_pkg::S_LOWER;
                    3'b011: op_next = rv_exec_pkg::U_LOWER;
                    3'b100: op_next = rv_exec_pkg::XOR;
                    3'b110: op_next = rv_exec_pkg::OR;
                    3'b111: op_next = rv_exec_pkg::AND;
                    3'b001: op_next = rv_exec_pkg::SHIFT_LEFT;
                    // SRAI has funct7 bit 5 set, SRLI clear
                    3'b101: op_next = dec.funct7[5] ? rv_exec_pkg::SHIFT_RIGHT_ARIT
                                                    : rv_exec_pkg::SHIFT_RIGHT_LOGIC;
                    default: op_next = rv_exec_pkg::ADD;
                endcase
            end
            rv_exec_pkg::OP: begin
                if (dec.funct7[5] == 1'b0) begin
                    case (dec.funct3)
                        3'b001: op_next = rv_exec_pkg::SHIFT_LEFT;
                        3'b010: op_next = rv_exec_pkg::S_LOWER;
                        3'b011: op_next = rv_exec_pkg::U_LOWER;
                        3'b100: op_next = rv_exec_pkg::XOR;
                        3'b101: op_next = rv_exec_pkg::SHIFT_RIGHT_LOGIC;
                        3'b110: op_next = rv_exec_pkg::OR;
                        3'b111: op_next = rv_exec_pkg::AND;
                        default: op_next = rv_exec_pkg::ADD;
                    endcase
                end else begin
                    case (dec.funct3)
                        3'b000: op_next = rv_exec_pkg::SUB;
                        3'b101: op_next = rv_exec_pkg::SHIFT_RIGHT_ARIT;
                        default: op_next = rv_exec_pkg::ADD;
                    endcase
                end
            end
            rv_exec_pkg::BRANCH: begin
                // Compare flavour resolved again in stage 3
                case (dec.funct3)
                    3'b000: op_next = rv_exec_pkg::SUB;
                    3'b001: op_next = rv_exec_pkg::XOR;
                    3'b100: op_next = rv_exec_pkg::S_LOWER;
                    3'b101: op_next = rv_exec_pkg::S_HIGH_EQ;
                    3'b110: op_next = rv_exec_pkg::U_LOWER;
                    3'b111: op_next = rv_exec_pkg::U_HIGH_EQ;
                    default: op_next = rv_exec_pkg::ADD;
                endcase
            end
            // Loads, stores, LUI, AUIPC and jumps all add
            default: op_next = rv_exec_pkg::ADD;
        endcase
    end

    always_comb begin
        ctl_next.valid     = dec.valid;
        ctl_next.op        = op_next;
        ctl_next.operand_a = dec.operand_a;
        ctl_next.operand_b = dec.operand_b;
        ctl_next.target    = dec.target;
        ctl_next.rd        = dec.rd;
        ctl_next.funct3    = dec.funct3;
        ctl_next.is_branch = (dec.option == rv_exec_pkg::BRANCH);
        ctl_next.is_jump   = dec.is_jump;
        ctl_next.writes_rd = (dec.option inside {rv_exec_pkg::OP, rv_exec_pkg::OP_IMM,
                                                 rv_exec_pkg::LUI, rv_exec_pkg::AUIPC,
                                                 rv_exec_pkg::JUMP, rv_exec_pkg::LOAD});
        ctl_next.is_load   = (dec.option == rv_exec_pkg::LOAD);
        ctl_next.illegal   = dec.illegal;
    end

    always_ff @(posedge clk) begin
        ctl <= ctl_next;
        if (rst) begin
            ctl.valid <= 1'b0;
        end
    end

endmodule

// File: rtl/alu.sv
// Stage 3 of the execute pipeline.
// Runs the selected ALU operation, resolves branch conditions and builds
// the registered result record with its write-back enable.
`timescale 1ns/1ns

module alu (
    input  logic                      clk,
    input  logic                      rst,
    input  rv_exec_pkg::ctl_stage_t   ctl,
    output rv_exec_pkg::exec_result_t out
);

    rv_exec_pkg::xlen_t        a;
    rv_exec_pkg::xlen_t        b;
    rv_exec_pkg::shamt_t       shamt;
    rv_exec_pkg::xlen_t        result;
    logic                      cond;
    rv_exec_pkg::exec_result_t out_next;

    assign a     = ctl.operand_a;
    assign b     = ctl.operand_b;
    assign shamt = b[4:0];

    always_comb begin
        case (ctl.op)
            rv_exec_pkg::ADD:               result = a + b;
            rv_exec_pkg::SUB:               result = a - b;
            rv_exec_pkg::AND:               result = a & b;
            rv_exec_pkg::OR:                result = a | b;
            rv_exec_pkg::XOR:               result = a ^ b;
            rv_exec_pkg::U_LOW_EQ:          result = {31'b0, a <= b};
            rv_exec_pkg::S_LOW_EQ:          result = {31'b0, $signed(a) <= $signed(b)};
            rv_exec_pkg::U_HIGH_EQ:         result = {31'b0, a >= b};
            rv_exec_pkg::S_HIGH_EQ:         result = {31'b0, $signed(a) >= $signed(b)};
            rv_exec_pkg::U_LOWER:           result = {31'b0, a < b};
            rv_exec_pkg::S_LOWER:           result = {31'b0, $signed(a) < $signed(b)};
            rv_exec_pkg::U_HIGHER:          result = {31'b0, a > b};
            rv_exec_pkg::S_HIGHER:          result = {31'b0, $signed(a) > $signed(b)};
            rv_exec_pkg::SHIFT_LEFT:        result = a << shamt;
            rv_exec_pkg::SHIFT_RIGHT_LOGIC: result = a >> shamt;
            rv_exec_pkg::SHIFT_RIGHT_ARIT:  result = $signed(a) >>> shamt;
            default:                        result = a + b;
        endcase
    end

    // BEQ and BNE reuse SUB and XOR, the rest are plain compares
    always_comb begin
        case (ctl.op)
            rv_exec_pkg::SUB: cond = (result == '0);
            rv_exec_pkg::XOR: cond = (result != '0);
            default:          cond = (result == 32'd1);
        endcase
    end

    always_comb begin
        out_next.valid        = ctl.valid;
        out_next.result       = result;
        out_next.rd           = ctl.rd;
        out_next.wb_en        = ctl.writes_rd && (ctl.rd != '0) && !ctl.is_load && !ctl.illegal;
        out_next.branch_taken = ctl.is_jump || (ctl.is_branch && cond);
        out_next.target       = ctl.target;
        out_next.illegal      = ctl.illegal;
    end

    always_ff @(posedge clk) begin
        out <= out_next;
        if (rst) begin
            out.valid <= 1'b0;
        end
    end

endmodule

// File: rtl/rv_exec_top.sv
// Execute section of a small RV32I core.
// Chains decode, ALU control and ALU, one register stage each, so a result
// leaves EXEC_LATENCY cycles after its instruction enters.
`timescale 1ns/1ns

module rv_exec_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      in_valid,
    input  rv_exec_pkg::instr_t       instr,
    input  rv_exec_pkg::xlen_t        pc,
    input  rv_exec_pkg::xlen_t        rs1_value,
    input  rv_exec_pkg::xlen_t        rs2_value,
    output rv_exec_pkg::exec_result_t out
);

    rv_exec_pkg::dec_stage_t dec;
    rv_exec_pkg::ctl_stage_t ctl;

    instr_decoder instr_decoder_i (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .instr     (instr),
        .pc        (pc),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .dec       (dec)
    );

    alu_controller alu_controller_i (
        .clk (clk),
        .rst (rst),
        .dec (dec),
        .ctl (ctl)
    );

    alu alu_i (
        .clk (clk),
        .rst (rst),
        .ctl (ctl),
        .out (out)
    );

endmodule

// File: tests/rv_exec_props.sv
// Concurrent checks on the execute pipeline outputs.
// Bound into rv_exec_top from here, so no testbench wiring is needed.
`timescale 1ns/1ns

module rv_exec_props (
    input logic                      clk,
    input logic                      rst,
    input logic                      in_valid,
    input rv_exec_pkg::exec_result_t out
);

    // Output slot is empty right after a reset edge
    a_reset_clears_valid: assert property (@(posedge clk) rst |=> !out.valid)
        else $error("out.valid high after reset");

    a_valid_latency_hi: assert property (@(posedge clk) disable iff (rst)
        in_valid |-> ##(rv_exec_pkg::EXEC_LATENCY) out.valid)
        else $error("valid input did not reach the output on time");

    a_valid_latency_lo: assert property (@(posedge clk) disable iff (rst)
        !in_valid |-> ##(rv_exec_pkg::EXEC_LATENCY) !out.valid)
        else $error("bubble turned into a valid output");

    a_no_wb_to_x0: assert property (@(posedge clk) disable iff (rst)
        out.valid |-> !(out.wb_en && out.rd == '0))
        else $error("write-back enabled for register zero");

endmodule

bind rv_exec_top rv_exec_props rv_exec_props_i (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in_valid),
    .out      (out)
);

// File: tests/tb_rv_exec.sv
// Random-stimulus testbench for the RV32I execute pipeline.
// A behavioral model queues the expected record of every valid instruction;
// each valid output is popped, compared and checked for its arrival cycle.
`timescale 1ns/1ns

module tb_rv_exec;

    logic clk;
    logic rst;
    logic in_valid;
    rv_exec_pkg::instr_t instr;
    rv_exec_pkg::xlen_t pc;
    rv_exec_pkg::xlen_t rs1_value;
    rv_exec_pkg::xlen_t rs2_value;
    rv_exec_pkg::exec_result_t out;

    integer seed = 32'h9ce2_8b2e;
    int cycle;
    int errors;
    int test_errors;
    int tests_run;
    int tests_failed;

    rv_exec_pkg::exec_result_t exp_q[$];
    logic [1:0] chk_q[$];
    string name_q[$];
    int due_q[$];

    rv_exec_top rv_exec_top_i (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .instr     (instr),
        .pc        (pc),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .out       (out)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // Kinds 0 OP, 1 OP_IMM, 2 BRANCH, 3 LUI, 4 AUIPC, 5 JAL, 6 JALR,
    // 7 LOAD, 8 STORE, 9 illegal
    function automatic rv_exec_pkg::instr_t make_instr(input int kind);
        logic [31:0] r;
        logic [2:0] f3;
        logic [6:0] f7;
        r = $random(seed);
        f3 = r[14:12];
        f7 = 7'b0;
        case (kind)
            0: begin
                if ((f3 == 3'b000 || f3 == 3'b101) && r[30]) f7 = 7'b0100000;
                return {f7, r[24:15], f3, r[11:7], 7'b0110011};
            end
            1: begin
                if (f3 == 3'b001) return {7'b0, r[24:15], f3, r[11:7], 7'b0010011};
                if (f3 == 3'b101) return {1'b0, r[30], 5'b0, r[24:15], f3, r[11:7], 7'b0010011};
                return {r[31:15], f3, r[11:7], 7'b0010011};
            end
            2: begin
                if (f3 == 3'b010 || f3 == 3'b011) f3 = 3'b000;
                return {r[31:15], f3, r[11:7], 7'b1100011};
            end
            3: return {r[31:7], 7'b0110111};
            4: return {r[31:7], 7'b0010111};
            5: return {r[31:7], 7'b1101111};
            6: return {r[31:15], 3'b000, r[11:7], 7'b1100111};
            7: return {r[31:15], 3'b010, r[11:7], 7'b0000011};
            8: return {r[31:15], 3'b010, r[11:7], 7'b0100011};
            default: begin
                case (r[1:0])
                    2'd0: return {r[31:7], 7'b0001111};
                    2'd1: return {r[31:7], 7'b1110011};
                    2'd2: return {r[31:7], 7'b0101011};
                    default: return {r[31:7], 7'b1011011};
                endcase
            end
        endcase
    endfunction

    // Expected record straight from the RV32I instruction rules
    function automatic rv_exec_pkg::exec_result_t predict(
        input rv_exec_pkg::instr_t i, input rv_exec_pkg::xlen_t p,
        input rv_exec_pkg::xlen_t x1, input rv_exec_pkg::xlen_t x2, output logic [1:0] chk);
        rv_exec_pkg::exec_result_t e;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] imm_u;
        logic [31:0] imm_j;
        logic [31:0] b;
        logic writes;
        imm_i = {{20{i[31]}}, i[31:20]};
        imm_s = {{20{i[31]}}, i[31:25], i[11:7]};
        imm_b = {{20{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
        imm_u = {i[31:12], 12'b0};
        imm_j = {{12{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
        e = '0;
        e.valid = 1'b1;
        e.rd = i[11:7];
        chk = 2'b01;
        writes = 1'b0;
        case (i[6:0])
            7'b0110011, 7'b0010011: begin
                b = (i[5]) ? x2 : imm_i;
                writes = 1'b1;
                case (i[14:12])
                    3'b000: e.result = (i[5] && i[30]) ? x1 - b : x1 + b;
                    3'b001: e.result = x1 << b[4:0];
                    3'b010: e.result = ($signed(x1) < $signed(b)) ? 32'd1 : 32'd0;
                    3'b011: e.result = (x1 < b) ? 32'd1 : 32'd0;
                    3'b100: e.result = x1 ^ b;
                    3'b101: begin
                        // Sign fill from bit 31 when funct7 bit 5 is set
                        if (i[30]) begin
                            e.result = $signed(x1) >>> b[4:0];
                        end else begin
                            e.result = x1 >> b[4:0];
                        end
                    end
                    3'b110: e.result = x1 | b;
                    default: e.result = x1 & b;
                endcase
            end
            7'b1100011: begin
                chk = 2'b10;
                e.target = p + imm_b;
                case (i[14:12])
                    3'b000: e.branch_taken = (x1 == x2);
                    3'b001: e.branch_taken = (x1 != x2);
                    3'b100: e.branch_taken = ($signed(x1) < $signed(x2));
                    3'b101: e.branch_taken = ($signed(x1) >= $signed(x2));
                    3'b110: e.branch_taken = (x1 < x2);
                    default: e.branch_taken = (x1 >= x2);
                endcase
            end
            7'b0110111: begin
                e.result = imm_u;
                writes = 1'b1;
            end
            7'b0010111: begin
                e.result = p + imm_u;
                writes = 1'b1;
            end
            7'b1101111, 7'b1100111: begin
                chk = 2'b11;
                e.result = p + 32'd4;
                e.target = i[3] ? p + imm_j : ((x1 + imm_i) & ~32'd1);
                e.branch_taken = 1'b1;
                writes = 1'b1;
            end
            7'b0000011: e.result = x1 + imm_i;
            7'b0100011: e.result = x1 + imm_s;
            default: begin
                chk = 2'b00;
                e.illegal = 1'b1;
            end
        endcase
        e.wb_en = writes && (i[11:7] != 5'd0);
        return e;
    endfunction

    task automatic report(input string name, input string field,
                          input logic [31:0] exp_v, input logic [31:0] act_v);
        $display("mismatch test=%s %s expected=%h actual=%h", name, field, exp_v, act_v);
        errors++;
        test_errors++;
    endtask

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        rv_exec_pkg::exec_result_t e;
        logic [1:0] chk;
        string name;
        int due;
        if (!rst && out.valid) begin
            if (exp_q.size() == 0) begin
                $display("error: valid output at cycle %0d with nothing in flight", cycle);
                errors++;
                test_errors++;
            end else begin
                e = exp_q.pop_front();
                chk = chk_q.pop_front();
                name = name_q.pop_front();
                due = due_q.pop_front();
                if (cycle != due) begin
                    report(name, "arrival_cycle", due, cycle);
                end
                if (out.illegal != e.illegal) report(name, "illegal", e.illegal, out.illegal);
                if (out.wb_en != e.wb_en) report(name, "wb_en", e.wb_en, out.wb_en);
                if (out.branch_taken != e.branch_taken) begin
                    report(name, "branch_taken", e.branch_taken, out.branch_taken);
                end
                if (chk[0] && out.result != e.result) report(name, "result", e.result, out.result);
                if (chk[1] && out.target != e.target) report(name, "target", e.target, out.target);
                if (e.wb_en && out.rd != e.rd) report(name, "rd", e.rd, out.rd);
            end
        end
    end

    task automatic issue(input string name, input int kind_lo, input int kind_hi,
                         input bit bubbles);
        int kind;
        logic [1:0] chk;
        @(posedge clk);
        #1;
        kind = kind_lo + ({$random(seed)} % (kind_hi - kind_lo + 1));
        instr = make_instr(kind);
        pc = {$random(seed)} & ~32'd3;
        rs1_value = $random(seed);
        rs2_value = ($random(seed) % 4 == 0) ? rs1_value : $random(seed);
        in_valid = !(bubbles && ($random(seed) % 4 == 0));
        if (in_valid) begin
            exp_q.push_back(predict(instr, pc, rs1_value, rs2_value, chk));
            chk_q.push_back(chk);
            name_q.push_back(name);
            due_q.push_back(cycle + rv_exec_pkg::EXEC_LATENCY);
        end
    endtask

    task automatic run_test(input string name, input int kind_lo, input int kind_hi,
                            input int count, input bit bubbles);
        int waited;
        test_errors = 0;
        for (int n = 0; n < count; n++) begin
            issue(name, kind_lo, kind_hi, bubbles);
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        waited = 0;
        while (exp_q.size() != 0 && waited < 20) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("error: test %s timed out with %0d results missing", name, exp_q.size());
            errors++;
            test_errors++;
            exp_q.delete();
            chk_q.delete();
            name_q.delete();
            due_q.delete();
        end
        tests_run++;
        if (test_errors != 0) tests_failed++;
        $display("test %s finished: %0d errors", name, test_errors);
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        in_valid = 1'b0;
        instr = '0;
        pc = '0;
        rs1_value = '0;
        rs2_value = '0;
        cycle = 0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        // Idle slots after reset must stay empty
        repeat (6) @(posedge clk);
        run_test("reg_reg", 0, 0, 200, 1'b0);
        run_test("reg_imm", 1, 1, 200, 1'b1);
        run_test("branch", 2, 2, 200, 1'b1);
        run_test("upper_jump", 3, 6, 200, 1'b1);
        run_test("mem_illegal", 7, 9, 200, 1'b1);
        run_test("stream", 0, 9, 1000, 1'b1);
        $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: rv_exec_top.f
rtl/rv_exec_pkg.sv
rtl/instr_decoder.sv
rtl/alu_controller.sv
rtl/alu.sv
rtl/rv_exec_top.sv
tests/rv_exec_props.sv
tests/tb_rv_exec.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_rv_exec
FILELIST  = rv_exec_top.f
LOG       = sim.log
FAIL_MSG  = FAIL: see errors above
PASS_MSG  = PASS: all tests

SRCS = $(shell grep -v '^+' $(FILELIST))
BIN  = obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
